/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // ========================================
    // Cache geometry
    // ========================================
    localparam int XLEN          = 32;                 // Processor word
    localparam int LINE_WORDS    = 4;
    localparam int LINE_BITS     = LINE_WORDS * XLEN;  // 128-bit line
    localparam int N_SETS        = 16;
    localparam int BYTE_OFS_BITS = 2;
    localparam int WORD_OFS_BITS = 2;
    localparam int INDEX_BITS    = 4;
    localparam int TAG_BITS      = XLEN - INDEX_BITS - WORD_OFS_BITS - BYTE_OFS_BITS;

    // Byte address, seen flat or split into cache fields
    typedef union packed {
        logic [XLEN-1:0] flat;
        struct packed {
            logic [TAG_BITS-1:0]      tag;
            logic [INDEX_BITS-1:0]    index;     // Set select
            logic [WORD_OFS_BITS-1:0] word_ofs;  // Word within line
            logic [BYTE_OFS_BITS-1:0] byte_ofs;
        } fields;
    } addr_u;

    typedef logic [LINE_WORDS-1:0][XLEN-1:0] line_t;  // Word 0 in low bits

endpackage

`default_nettype wire

/* rtl/dcache_way_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Set-array access, controller to way storage
interface dcache_way_if #(
    parameter int N_WAYS = 4
);
    localparam int WAY_BITS = $clog2(N_WAYS);

    // From controller
    logic [dcache_pkg::INDEX_BITS-1:0] index;     // Set under access
    logic [dcache_pkg::TAG_BITS-1:0]   tag;       // Request tag, compared and written
    logic [N_WAYS-1:0]                 wr_way;    // One-hot write enable
    dcache_pkg::line_t                 wr_line;
    logic                              set_dirty;
    logic                              set_valid;
    logic [WAY_BITS-1:0]               sel_way;   // Victim readout select

    // From way storage
    logic                              hit;
    logic [WAY_BITS-1:0]               hit_way;
    dcache_pkg::line_t                 hit_line;
    logic [dcache_pkg::TAG_BITS-1:0]   sel_tag;
    dcache_pkg::line_t                 sel_line;
    logic                              sel_dirty;

    modport ctrl (
        output index, tag, wr_way, wr_line, set_dirty, set_valid, sel_way,
        input  hit, hit_way, hit_line, sel_tag, sel_line, sel_dirty
    );

    modport store (
        input  index, tag, wr_way, wr_line, set_dirty, set_valid, sel_way,
        output hit, hit_way, hit_line, sel_tag, sel_line, sel_dirty
    );

endinterface

`default_nettype wire

/* rtl/dcache_line_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_line_merge (
    input  wire logic [dcache_pkg::WORD_OFS_BITS-1:0] word_ofs_i,
    input  wire dcache_pkg::line_t                    base_line_i,
    input  wire logic [dcache_pkg::XLEN/8-1:0]        be_i,      // Store byte enables
    input  wire logic [dcache_pkg::XLEN-1:0]          data_i,
    output logic      [dcache_pkg::XLEN-1:0]          word_o,    // Unmerged, for loads
    output dcache_pkg::line_t                         line_o
);

    // ========================================
    // Word select and byte merge
    // ========================================
    logic [dcache_pkg::XLEN-1:0] merged_word;

    always_comb
    begin
        word_o      = base_line_i[word_ofs_i];
        merged_word = word_o;
        for (int b = 0; b < dcache_pkg::XLEN / 8; b++)
        begin
            // Enabled byte taken from store data
            if (be_i[b])
                merged_word[8*b +: 8] = data_i[8*b +: 8];
        end
    end

    // Other words of the line pass through
    always_comb
    begin
        line_o             = base_line_i;
        line_o[word_ofs_i] = merged_word;
    end

endmodule

`default_nettype wire

/* rtl/dcache_fifo_repl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_fifo_repl #(
    parameter int N_WAYS = 4
) (
    input  wire logic                                clk_i,
    input  wire logic                                rst_i,
    input  wire logic [dcache_pkg::INDEX_BITS-1:0]   index_i,
    input  wire logic                                adv_i,    // Fill done in this set
    output logic      [$clog2(N_WAYS)-1:0]           victim_o
);

    localparam int WAY_BITS = $clog2(N_WAYS);

    logic [WAY_BITS-1:0] cnt_q [dcache_pkg::N_SETS];  // Next way to replace, per set

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < dcache_pkg::N_SETS; s++)
                cnt_q[s] <= '0;
        end
        else if (adv_i)
        begin
            if (cnt_q[index_i] == WAY_BITS'(N_WAYS - 1))
                cnt_q[index_i] <= '0;                    // Wrap to way 0
            else
                cnt_q[index_i] <= cnt_q[index_i] + 1'b1;
        end
    end

    assign victim_o = cnt_q[index_i];

endmodule

`default_nettype wire

/* rtl/dcache_ways.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ways #(
    parameter int N_WAYS = 4
) (
    input  wire logic   clk_i,
    input  wire logic   rst_i,
    dcache_way_if.store way_if
);

    localparam int WAY_BITS = $clog2(N_WAYS);

    // ========================================
    // Storage
    // ========================================
    logic [dcache_pkg::TAG_BITS-1:0] tag_mem  [N_WAYS][dcache_pkg::N_SETS];
    dcache_pkg::line_t               line_mem [N_WAYS][dcache_pkg::N_SETS];
    logic [N_WAYS-1:0][dcache_pkg::N_SETS-1:0] valid_q;   // Flip-flops, cleared on reset
    logic [N_WAYS-1:0][dcache_pkg::N_SETS-1:0] dirty_q;
    logic [N_WAYS-1:0]               hit_vec;

    // Tag and line writes land on the next clock
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way_if.wr_way[w])
            begin
                tag_mem[w][way_if.index]  <= way_if.tag;
                line_mem[w][way_if.index] <= way_if.wr_line;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else
        begin
            for (int w = 0; w < N_WAYS; w++)
            begin
                if (way_if.wr_way[w])
                begin
                    if (way_if.set_valid)
                        valid_q[w][way_if.index] <= 1'b1;
                    dirty_q[w][way_if.index] <= way_if.set_dirty;
                end
            end
        end
    end

    // ========================================
    // Hit detection, combinational
    // ========================================
    always_comb
    begin
        way_if.hit_way = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            hit_vec[w] = valid_q[w][way_if.index] && (tag_mem[w][way_if.index] == way_if.tag);
            if (hit_vec[w])
                way_if.hit_way = WAY_BITS'(w);  // At most one way matches
        end
    end

    assign way_if.hit      = |hit_vec;
    assign way_if.hit_line = line_mem[way_if.hit_way][way_if.index];

    // Victim readout
    assign way_if.sel_tag   = tag_mem[way_if.sel_way][way_if.index];
    assign way_if.sel_line  = line_mem[way_if.sel_way][way_if.index];
    assign way_if.sel_dirty = valid_q[way_if.sel_way][way_if.index]
                           && dirty_q[way_if.sel_way][way_if.index];

endmodule

`default_nettype wire

/* rtl/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl #(
    parameter int N_WAYS = 4
) (
    input  wire logic                              clk_i,
    input  wire logic                              rst_i,
    input  wire logic                              p_strobe_i,
    input  wire logic                              p_rw_i,
    input  wire logic [dcache_pkg::XLEN/8-1:0]     p_be_i,
    input  wire logic [dcache_pkg::XLEN-1:0]       p_addr_i,
    input  wire logic [dcache_pkg::XLEN-1:0]       p_data_i,
    output logic      [dcache_pkg::XLEN-1:0]       p_data_o,
    output logic                                   p_ready_o,
    output logic                                   m_strobe_o,
    output logic                                   m_rw_o,
    output logic      [dcache_pkg::XLEN-1:0]       m_addr_o,
    output dcache_pkg::line_t                      m_data_o,
    input  wire dcache_pkg::line_t                 m_data_i,
    input  wire logic                              m_ready_i,
    dcache_way_if.ctrl                             way_if,
    input  wire logic [$clog2(N_WAYS)-1:0]         victim_i,
    output logic                                   repl_adv_o,
    output dcache_pkg::addr_u                      merge_word_o,
    output logic      [dcache_pkg::XLEN-1:0]       merge_data_o,
    output logic      [dcache_pkg::XLEN/8-1:0]     merge_be_o,
    output dcache_pkg::line_t                      merge_line_o,
    input  wire dcache_pkg::line_t                 merged_line_i,
    input  wire logic [dcache_pkg::XLEN-1:0]       read_word_i
);

    // ========================================
    // FSM encoding
    // ========================================
    localparam logic [2:0] S_IDLE     = 3'd0,
                           S_ANALYSIS = 3'd1,  // Tag compare, hit answers here
                           S_WB       = 3'd2,  // Dirty victim to memory
                           S_WB_FIN   = 3'd3,
                           S_RD       = 3'd4,  // Line fill
                           S_RD_FIN   = 3'd5;

    logic [2:0]                    state_q;
    logic [2:0]                    state_d;
    dcache_pkg::addr_u             req_addr;   // Registered request
    logic                          req_rw;
    logic [dcache_pkg::XLEN/8-1:0] req_be;
    logic [dcache_pkg::XLEN-1:0]   req_data;
    dcache_pkg::line_t             fill_line;  // Captured on m_ready_i
    dcache_pkg::addr_u             wb_addr;
    dcache_pkg::addr_u             rd_addr;
    logic                          write_hit;
    logic                          start_wb;
    logic                          start_rd;

    assign write_hit = (state_q == S_ANALYSIS) && way_if.hit && req_rw;
    assign start_wb  = (state_q == S_ANALYSIS) && !way_if.hit && way_if.sel_dirty;
    assign start_rd  = ((state_q == S_ANALYSIS) && !way_if.hit && !way_if.sel_dirty)
                    || (state_q == S_WB_FIN);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:     if (p_strobe_i) state_d = S_ANALYSIS;
            S_ANALYSIS: state_d = way_if.hit ? S_IDLE : (start_wb ? S_WB : S_RD);
            S_WB:       if (m_ready_i) state_d = S_WB_FIN;
            S_WB_FIN:   state_d = S_RD;
            S_RD:       if (m_ready_i) state_d = S_RD_FIN;
            S_RD_FIN:   state_d = S_IDLE;
            default:    state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= S_IDLE;
        else
            state_q <= state_d;
    end

    // Request and fill payload
    always_ff @(posedge clk_i)
    begin
        if (state_q == S_IDLE && p_strobe_i)
        begin
            req_addr.flat <= p_addr_i;
            req_rw        <= p_rw_i;
            req_be        <= p_be_i;
            req_data      <= p_data_i;
        end
        if (state_q == S_RD && m_ready_i)
            fill_line <= m_data_i;
    end

    // ========================================
    // Memory request, one strobe per phase
    // ========================================
    always_comb
    begin
        wb_addr.fields = '{way_if.sel_tag, req_addr.fields.index, '0, '0};  // Victim line
        rd_addr.fields = '{req_addr.fields.tag, req_addr.fields.index, '0, '0};
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
        end
        else
        begin
            m_strobe_o <= start_wb || start_rd;
            if (start_wb || start_rd)
                m_rw_o <= start_wb;             // Held until the next phase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (start_wb)
        begin
            m_addr_o <= wb_addr.flat;
            m_data_o <= way_if.sel_line;
        end
        else if (start_rd)
            m_addr_o <= rd_addr.flat;
    end

    // ========================================
    // Way storage access
    // ========================================
    assign way_if.index     = req_addr.fields.index;
    assign way_if.tag       = req_addr.fields.tag;
    assign way_if.sel_way   = victim_i;
    assign way_if.set_valid = (state_q == S_RD_FIN);
    assign way_if.set_dirty = (state_q == S_RD_FIN) ? req_rw : 1'b1;  // Store fills go dirty
    assign way_if.wr_line   = (state_q == S_RD_FIN && !req_rw) ? fill_line : merged_line_i;

    always_comb
    begin
        way_if.wr_way = '0;
        if (write_hit)
            way_if.wr_way[way_if.hit_way] = 1'b1;
        else if (state_q == S_RD_FIN)
            way_if.wr_way[victim_i] = 1'b1;   // Fill into FIFO victim
    end

    assign repl_adv_o = (state_q == S_RD_FIN);

    // Merge inputs, base line from fill on a miss
    assign merge_word_o = req_addr;
    assign merge_data_o = req_data;
    assign merge_be_o   = req_be;
    assign merge_line_o = (state_q == S_RD_FIN) ? fill_line : way_if.hit_line;

    // Processor answer
    assign p_ready_o = ((state_q == S_ANALYSIS) && way_if.hit) || (state_q == S_RD_FIN);
    assign p_data_o  = (p_ready_o && !req_rw) ? read_word_i : '0;

endmodule

`default_nettype wire

/* rtl/dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache #(
    parameter int N_WAYS = 4
) (
    input  wire logic                                clk_i,
    input  wire logic                                rst_i,
    // Processor side
    input  wire logic                                p_strobe_i,
    input  wire logic                                p_rw_i,      // 1 = store
    input  wire logic [dcache_pkg::XLEN/8-1:0]       p_be_i,
    input  wire logic [dcache_pkg::XLEN-1:0]         p_addr_i,
    input  wire logic [dcache_pkg::XLEN-1:0]         p_data_i,
    output logic      [dcache_pkg::XLEN-1:0]         p_data_o,
    output logic                                     p_ready_o,
    // Memory side, whole lines
    output logic                                     m_strobe_o,
    output logic                                     m_rw_o,
    output logic      [dcache_pkg::XLEN-1:0]         m_addr_o,
    output logic      [dcache_pkg::LINE_BITS-1:0]    m_data_o,
    input  wire logic [dcache_pkg::LINE_BITS-1:0]    m_data_i,
    input  wire logic                                m_ready_i
);

    localparam int WAY_BITS = $clog2(N_WAYS);

    logic [WAY_BITS-1:0]             victim;
    logic                            repl_adv;
    dcache_pkg::addr_u               merge_addr;   // Request address for word select
    logic [dcache_pkg::XLEN-1:0]     merge_data;
    logic [dcache_pkg::XLEN/8-1:0]   merge_be;
    dcache_pkg::line_t               merge_line;   // Hit line or fill line
    dcache_pkg::line_t               merged_line;
    logic [dcache_pkg::XLEN-1:0]     read_word;

    dcache_way_if #(.N_WAYS(N_WAYS)) way_if ();

    dcache_ctrl #(.N_WAYS(N_WAYS)) u_ctrl (
        .clk_i, .rst_i,
        .p_strobe_i, .p_rw_i, .p_be_i, .p_addr_i, .p_data_i, .p_data_o, .p_ready_o,
        .m_strobe_o, .m_rw_o, .m_addr_o, .m_data_o, .m_data_i, .m_ready_i,
        .way_if        (way_if.ctrl),
        .victim_i      (victim),
        .repl_adv_o    (repl_adv),
        .merge_word_o  (merge_addr),
        .merge_data_o  (merge_data),
        .merge_be_o    (merge_be),
        .merge_line_o  (merge_line),
        .merged_line_i (merged_line),
        .read_word_i   (read_word)
    );

    dcache_ways #(.N_WAYS(N_WAYS)) u_ways (
        .clk_i, .rst_i,
        .way_if (way_if.store)
    );

    dcache_fifo_repl #(.N_WAYS(N_WAYS)) u_repl (
        .clk_i, .rst_i,
        .index_i  (way_if.index),
        .adv_i    (repl_adv),
        .victim_o (victim)
    );

    dcache_line_merge u_merge (
        .word_ofs_i  (merge_addr.fields.word_ofs),
        .base_line_i (merge_line),
        .be_i        (merge_be),
        .data_i      (merge_data),
        .word_o      (read_word),
        .line_o      (merged_line)
    );

endmodule

`default_nettype wire

/* bench/tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

// Line-granular main memory, one request at a time
module tb_mem_model #(
    parameter int READY_DELAY = 3               // Cycles from strobe to ready
) (
    input  wire logic         clk_i,
    input  wire logic         rst_i,
    input  wire logic         strobe_i,
    input  wire logic         rw_i,             // 1 = line write
    input  wire logic [31:0]  addr_i,
    input  wire logic [127:0] data_i,
    output logic      [127:0] data_o,
    output logic              ready_o
);

    logic [127:0] mem [1024];                   // 16 KB, line select addr_i[13:4]
    logic [9:0]   line_idx;
    logic         is_write;
    logic [127:0] wr_line;

    // Preload pattern, every address bit counts
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e3779b9) ^ 32'h5ac31e87;
    endfunction

    initial
    begin
        ready_o = 1'b0;
        data_o  = '0;
        for (int l = 0; l < 1024; l++)
            for (int w = 0; w < 4; w++)
                mem[l][32*w +: 32] = fill_word({18'b0, l[9:0], w[1:0], 2'b00});
        forever
        begin
            @(negedge clk_i);                   // Strobe is stable here
            if (!rst_i && strobe_i)
            begin
                line_idx = addr_i[13:4];
                is_write = rw_i;
                wr_line  = data_i;
                repeat (READY_DELAY) @(posedge clk_i);
                #2;
                if (is_write)
                    mem[line_idx] = wr_line;
                else
                    data_o = mem[line_idx];
                ready_o = 1'b1;
                @(posedge clk_i);
                #2;
                ready_o = 1'b0;                 // Single-cycle pulse
            end
        end
    end

endmodule

`default_nettype wire

/* bench/dcache_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

// Handshake properties on the cache ports
module dcache_asserts (
    input wire logic        clk_i,
    input wire logic        rst_i,
    input wire logic        p_ready_o,
    input wire logic        m_strobe_o,
    input wire logic        m_ready_i,
    input wire logic [31:0] m_addr_o
);

    int   fail_cnt = 0;     // Failed assertions so far
    logic mem_wait;         // Strobe sent, ready not yet seen

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            mem_wait <= 1'b0;
        else if (m_strobe_o)
            mem_wait <= 1'b1;
        else if (m_ready_i)
            mem_wait <= 1'b0;
    end

    a_no_strobe_in_wait: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_wait |-> !m_strobe_o)
    else
    begin
        $error("m_strobe_o raised while waiting for m_ready_i");
        fail_cnt++;
    end

    a_line_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o |-> (m_addr_o[3:0] == 4'b0000))
    else
    begin
        $error("m_addr_o not line-aligned on strobe");
        fail_cnt++;
    end

    // Ready lasts exactly one cycle
    a_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_o |=> !p_ready_o)
    else
    begin
        $error("p_ready_o held longer than one cycle");
        fail_cnt++;
    end

endmodule

bind dcache dcache_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .p_ready_o  (p_ready_o),
    .m_strobe_o (m_strobe_o),
    .m_ready_i  (m_ready_i),
    .m_addr_o   (m_addr_o)
);

`default_nettype wire

/* bench/tb_dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;

    localparam int N_WAYS      = 4;
    localparam int CLK_PERIOD  = 20;
    localparam int MISS_CYCLES = 16;            // Worst miss, write-back plus fill
    localparam int N_RAND      = 200;
    localparam int N_REQ       = 2 + 7 + 2 + (N_WAYS + 2) + N_RAND;
    localparam int WATCHDOG_NS = (N_REQ * (MISS_CYCLES + 2) + 20) * CLK_PERIOD;
    localparam logic [3:0] BE_SET [3] = '{4'b0001, 4'b0110, 4'b1111};

    logic         clk = 1'b0;
    logic         rst;
    logic         p_strobe;
    logic         p_rw;
    logic [3:0]   p_be;
    logic [31:0]  p_addr;
    logic [31:0]  p_wdata;
    logic [31:0]  p_rdata;
    logic         p_ready;
    logic         m_strobe;
    logic         m_rw;
    logic [31:0]  m_addr;
    logic [127:0] m_wdata;
    logic [127:0] m_rdata;
    logic         m_ready;

    logic [31:0]  shadow [4096];                // Word copy of memory, index addr[13:2]
    logic [31:0]  rng_state = 32'h89f94326;
    int           errors = 0;
    int           checks = 0;
    int           tests  = 0;
    logic         mon_rw [$];                   // m_rw_o of each memory strobe
    logic [31:0]  last_wr_addr;
    logic [127:0] last_wr_line;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache #(.N_WAYS(N_WAYS)) UUT (
        .clk_i      (clk),
        .rst_i      (rst),
        .p_strobe_i (p_strobe),
        .p_rw_i     (p_rw),
        .p_be_i     (p_be),
        .p_addr_i   (p_addr),
        .p_data_i   (p_wdata),
        .p_data_o   (p_rdata),
        .p_ready_o  (p_ready),
        .m_strobe_o (m_strobe),
        .m_rw_o     (m_rw),
        .m_addr_o   (m_addr),
        .m_data_o   (m_wdata),
        .m_data_i   (m_rdata),
        .m_ready_i  (m_ready)
    );

    tb_mem_model u_mem (
        .clk_i    (clk),
        .rst_i    (rst),
        .strobe_i (m_strobe),
        .rw_i     (m_rw),
        .addr_i   (m_addr),
        .data_i   (m_wdata),
        .data_o   (m_rdata),
        .ready_o  (m_ready)
    );

    // Memory-side monitor
    always @(negedge clk)
    begin
        if (!rst && m_strobe)
        begin
            mon_rw.push_back(m_rw);
            if (m_rw)
            begin
                last_wr_addr = m_addr;
                last_wr_line = m_wdata;
            end
        end
    end

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] initial_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e3779b9) ^ 32'h5ac31e87;  // Same as memory preload
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] make_addr(input logic [31:0] tag, input logic [31:0] set,
                                              input logic [31:0] word);
        dcache_pkg::addr_u a;
        a.fields.tag      = tag[dcache_pkg::TAG_BITS-1:0];
        a.fields.index    = set[dcache_pkg::INDEX_BITS-1:0];
        a.fields.word_ofs = word[dcache_pkg::WORD_OFS_BITS-1:0];
        a.fields.byte_ofs = '0;
        return a.flat;
    endfunction

    // Enabled bytes from data, the rest from old
    function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic logic [127:0] shadow_line(input logic [31:0] addr);
        logic [11:0] base;
        base = {addr[13:4], 2'b00};
        return {shadow[base + 12'd3], shadow[base + 12'd2], shadow[base + 12'd1], shadow[base]};
    endfunction

    function automatic int strobes(input logic rw);
        int n;
        n = 0;
        foreach (mon_rw[i])
            if (mon_rw[i] == rw)
                n++;
        return n;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    // One processor request, called and returning at posedge + 2 ns
    task automatic cpu_access(input logic rw, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output int lat);
        p_strobe = 1'b1;
        p_rw     = rw;
        p_be     = be;
        p_addr   = addr;
        p_wdata  = data;
        @(posedge clk);
        #2;
        p_strobe = 1'b0;
        lat      = 0;
        rdata    = '0;
        do
        begin
            @(negedge clk);
            lat++;
            rdata = p_rdata;                    // Valid in the ready cycle only
        end
        while (!p_ready && lat < MISS_CYCLES);
        if (!p_ready)
        begin
            errors++;
            $display("No p_ready_o within %0d cycles for address %h", MISS_CYCLES, addr);
        end
        else if (rw)
            shadow[addr[13:2]] = byte_merge(shadow[addr[13:2]], data, be);
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("test %-24s ok", name);
        else
            $display("test %-24s %0d error(s)", name, errors - err_before);
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic read_miss_then_hit();
        logic [31:0] a;
        logic [31:0] rd;
        int          lat;
        int          err0;
        err0 = errors;
        a    = make_addr(1, 0, 2);
        mon_rw.delete();
        cpu_access(1'b0, 4'h0, a, '0, rd, lat);
        check("p_data_o miss", rd, shadow[a[13:2]]);
        check("fill reads", strobes(1'b0), 1);
        check("memory writes", strobes(1'b1), 0);
        mon_rw.delete();
        cpu_access(1'b0, 4'h0, a, '0, rd, lat);
        check("hit latency", lat, 1);
        check("p_data_o hit", rd, shadow[a[13:2]]);
        check("hit strobes", mon_rw.size(), 0);
        end_test("read_miss_then_hit", err0);
    endtask

    task automatic byte_enable_store_hit();
        logic [31:0] a;
        logic [31:0] rd;
        logic [31:0] old;
        logic [31:0] wd;
        int          lat;
        int          err0;
        err0 = errors;
        a    = make_addr(2, 1, 3);
        cpu_access(1'b0, 4'h0, a, '0, rd, lat);        // Make the line resident
        for (int i = 0; i < 3; i++)
        begin
            old = shadow[a[13:2]];
            wd  = next_rand();
            mon_rw.delete();
            cpu_access(1'b1, BE_SET[i], a, wd, rd, lat);
            check("store hit latency", lat, 1);
            check("store hit strobes", mon_rw.size(), 0);
            cpu_access(1'b0, 4'h0, a, '0, rd, lat);
            check("p_data_o after store", rd, byte_merge(old, wd, BE_SET[i]));
        end
        end_test("byte_enable_store_hit", err0);
    endtask

    task automatic store_miss_allocate();
        logic [31:0] a;
        logic [31:0] rd;
        logic [31:0] wd;
        int          lat;
        int          err0;
        err0 = errors;
        a    = make_addr(3, 2, 1);
        wd   = next_rand();
        mon_rw.delete();
        cpu_access(1'b1, 4'b1010, a, wd, rd, lat);
        check("allocate reads", strobes(1'b0), 1);
        cpu_access(1'b0, 4'h0, a, '0, rd, lat);
        check("read-back latency", lat, 1);
        check("p_data_o merged", rd, byte_merge(initial_word(a), wd, 4'b1010));
        check("memory writes", strobes(1'b1), 0);          // Line stays dirty in cache
        end_test("store_miss_allocate", err0);
    endtask

    task automatic fifo_evict_writeback();
        logic [31:0] first;
        logic [31:0] rd;
        logic [31:0] wd;
        int          lat;
        int          err0;
        err0  = errors;
        first = make_addr(10, 3, 0);
        wd    = next_rand();
        cpu_access(1'b1, 4'hf, first, wd, rd, lat);      // Dirty line in FIFO slot 0
        for (int t = 1; t < N_WAYS; t++)
            cpu_access(1'b0, 4'h0, make_addr(10 + t, 3, 0), '0, rd, lat);
        mon_rw.delete();
        cpu_access(1'b0, 4'h0, make_addr(10 + N_WAYS, 3, 0), '0, rd, lat);
        check("eviction strobes", mon_rw.size(), 2);
        if (mon_rw.size() == 2)
            check("m_rw_o order", {mon_rw[0], mon_rw[1]}, 2'b10);   // Write-back, then fill
        check("m_addr_o write-back", last_wr_addr, first);
        check("m_data_o write-back", last_wr_line, shadow_line(first));
        mon_rw.delete();
        cpu_access(1'b0, 4'h0, first, '0, rd, lat);
        check("refetch reads", strobes(1'b0), 1);
        check("p_data_o refetch", rd, wd);
        end_test("fifo_evict_writeback", err0);
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] rd;
        logic [31:0] exp;
        int          lat;
        int          err0;
        err0 = errors;
        for (int n = 0; n < N_RAND; n++)
        begin
            r = next_rand();
            a = make_addr(32'd20 + (r[30:28] % 3'd6), 32'd8 + (r[27:26] % 2'd3), r[25:24]);
            if (r[23])
                cpu_access(1'b1, r[19:16], a, next_rand(), rd, lat);
            else
            begin
                exp = shadow[a[13:2]];
                cpu_access(1'b0, 4'h0, a, '0, rd, lat);
                check("p_data_o random read", rd, exp);
            end
        end
        end_test("random_traffic", err0);
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial
    begin
        for (int i = 0; i < 4096; i++)
            shadow[i] = initial_word({18'b0, i[11:0], 2'b00});
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_be     = 4'h0;
        p_addr   = '0;
        p_wdata  = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        // Idle outputs straight out of reset
        check("p_ready_o after reset", p_ready, 1'b0);
        check("m_strobe_o after reset", m_strobe, 1'b0);
        check("m_rw_o after reset", m_rw, 1'b0);
        read_miss_then_hit();
        byte_enable_store_hit();
        store_miss_allocate();
        fifo_evict_writeback();
        random_traffic();
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, UUT.u_asserts.fail_cnt);
        if (errors == 0 && UUT.u_asserts.fail_cnt == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, requests did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dcache.f */
rtl/dcache_pkg.sv
rtl/dcache_way_if.sv
rtl/dcache_line_merge.sv
rtl/dcache_fifo_repl.sv
rtl/dcache_ways.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
bench/tb_mem_model.sv
bench/dcache_asserts.sv
bench/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f dcache.f -o sim_dcache

./obj_dir/sim_dcache +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi
